//--- design/rv32_pkg.sv
package rv32_pkg;

	parameter int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [4:0] reg_idx_t;

	// standard rv32i major opcodes
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111,
		SYS   = 7'b1110011
	} opcode_t;

	typedef logic [2:0] funct3_t;

	// I-forms reuse these codes
	localparam funct3_t ADD  = 3'b000;
	localparam funct3_t SUB  = 3'b000; // funct7[5] set
	localparam funct3_t SLL  = 3'b001;
	localparam funct3_t SLT  = 3'b010;
	localparam funct3_t SLTU = 3'b011;
	localparam funct3_t XOR  = 3'b100;
	localparam funct3_t SRL  = 3'b101;
	localparam funct3_t SRA  = 3'b101; // funct7[5] set
	localparam funct3_t OR   = 3'b110;
	localparam funct3_t AND  = 3'b111;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		funct3_t    funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} r_fields_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		funct3_t     funct3;
		reg_idx_t    rd;
		opcode_t     opcode;
	} i_fields_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_idx_t    rd;
		opcode_t     opcode;
	} u_fields_t;

	// one instruction word viewed by format
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		u_fields_t u;
	} instr_t;

endpackage

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv32_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output data_t    rd1,
	output data_t    rd2,
	input  logic     we,
	input  reg_idx_t waddr,
	input  data_t    wdata
);

	data_t regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin // x0 never written
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		if (rs1 == '0) begin
			rd1 = '0;
		end else begin
			rd1 = regs[rs1];
		end
	end

	always_comb begin
		if (rs2 == '0) begin
			rd2 = '0;
		end else begin
			rd2 = regs[rs2];
		end
	end

endmodule

//--- design/instr_queue.sv
`timescale 1ns/1ns

module instr_queue import rv32_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  instr_t in_instr,
	input  data_t  in_pc,
	output logic   in_credit,
	output logic   q_valid,
	output instr_t q_instr,
	output data_t  q_pc,
	input  logic   q_pop
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	instr_t mem_instr [DEPTH];
	data_t  mem_pc    [DEPTH];

	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem_instr[wr_ptr] <= in_instr;
			mem_pc[wr_ptr]    <= in_pc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (q_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count     <= count + CW'(in_valid) - CW'(q_pop);
			in_credit <= q_pop; // one credit per freed entry
		end
	end

	assign q_valid = (count != '0);
	assign q_instr = mem_instr[rd_ptr];
	assign q_pc    = mem_pc[rd_ptr];

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu import rv32_pkg::*; (
	input  instr_t instr,
	input  data_t  a_in,
	input  data_t  b_in,
	output data_t  c_out,
	output logic   rd_wr
);

	opcode_t opcode;
	funct3_t funct3;
	logic    alu_op; // R or I arithmetic group
	logic    sub_op;
	logic    arith;
	logic    lt_signed, lt_unsigned;
	logic [4:0] shamt;

	data_t and_result;
	data_t or_result;
	data_t xor_result;
	data_t shift_result;
	data_t set_result;
	data_t add_sub_result;
	data_t addend;
	logic [XLEN:0] adder_out;

	always_comb begin
		opcode = instr.r.opcode;
		funct3 = instr.r.funct3;
		shamt  = b_in[4:0];
		alu_op = (opcode == R) || (opcode == I);
		arith  = (funct3 == SRA) && instr.r.funct7[5]; // bit 30 is imm[10] for SRAI
	end

	assign and_result = a_in & b_in;
	assign or_result  = a_in | b_in;
	assign xor_result = a_in ^ b_in;

	always_comb begin
		case (funct3)
			SLL:     shift_result = a_in << shamt;
			SRL:     shift_result = arith ? data_t'($signed(a_in) >>> shamt) : a_in >> shamt;
			default: shift_result = '0;
		endcase
	end

	// single adder subtracts for SUB and both compares
	always_comb begin
		sub_op = ((opcode == R) && (funct3 == SUB) && instr.r.funct7[5])
			|| (alu_op && (funct3 == SLT || funct3 == SLTU));
		addend         = sub_op ? ~b_in : b_in;
		adder_out      = {1'b0, a_in} + {1'b0, addend} + (XLEN + 1)'(sub_op);
		add_sub_result = adder_out[XLEN-1:0];
	end

	always_comb begin
		lt_unsigned = ~adder_out[XLEN]; // borrow out of a - b
		if (a_in[XLEN-1] != b_in[XLEN-1]) begin
			lt_signed = a_in[XLEN-1];
		end else begin
			lt_signed = adder_out[XLEN-1];
		end
		if (funct3 == SLTU) begin
			set_result = data_t'(lt_unsigned);
		end else begin
			set_result = data_t'(lt_signed);
		end
	end

	always_comb begin
		c_out = '0;
		rd_wr = 1'b0;
		case (opcode)
			R, I: begin
				case (funct3)
					ADD:       c_out = add_sub_result; // SUB shares the code
					AND:       c_out = and_result;
					OR:        c_out = or_result;
					XOR:       c_out = xor_result;
					SLT, SLTU: c_out = set_result;
					SLL, SRL:  c_out = shift_result;
					default:   c_out = '0;
				endcase
				rd_wr = 1'b1;
			end
			LUI: begin
				c_out = b_in; // imm already shifted
				rd_wr = 1'b1;
			end
			AUIPC, JAL, JALR, LOAD: begin
				c_out = add_sub_result;
				rd_wr = 1'b1;
			end
			STORE: begin
				c_out = add_sub_result; // address only
				rd_wr = 1'b0;
			end
			B, MEM, SYS: begin
				c_out = '0;
				rd_wr = 1'b0;
			end
			default: begin
				c_out = '0;
				rd_wr = 1'b0;
			end
		endcase
	end

endmodule

//--- design/exec_stage.sv
`timescale 1ns/1ns

module exec_stage import rv32_pkg::*; #(
	parameter int OUT_CREDITS = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     q_valid,
	input  instr_t   q_instr,
	input  data_t    q_pc,
	output logic     q_pop,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	input  data_t    rd1,
	input  data_t    rd2,
	output instr_t   alu_instr,
	output data_t    a_in,
	output data_t    b_in,
	input  data_t    c_out,
	input  logic     rd_wr,
	output logic     we,
	output reg_idx_t waddr,
	output data_t    wdata,
	output logic     res_valid,
	output reg_idx_t res_rd,
	output data_t    res_data,
	output logic     res_wr,
	input  logic     res_credit
);

	localparam int CW = $clog2(OUT_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          issue;
	opcode_t       opcode;

	assign opcode    = q_instr.r.opcode;
	assign rs1       = q_instr.r.rs1;
	assign rs2       = q_instr.r.rs2;
	assign alu_instr = q_instr;

	assign issue = q_valid && (credits != '0);
	assign q_pop = issue;

	always_comb begin
		if (opcode == AUIPC || opcode == JAL) begin
			a_in = q_pc;
		end else begin
			a_in = rd1;
		end
	end

	always_comb begin
		case (opcode)
			R:              b_in = rd2;
			I, JALR, LOAD:  b_in = {{(XLEN-12){q_instr.i.imm[11]}}, q_instr.i.imm};
			STORE:          b_in = {{(XLEN-12){q_instr.r.funct7[6]}}, q_instr.r.funct7,
						q_instr.r.rd}; // S-imm split over funct7/rd
			LUI, AUIPC:     b_in = {q_instr.u.imm, 12'b0};
			JAL:            b_in = data_t'(4); // link = pc+4
			default:        b_in = rd2;
		endcase
	end

	// writeback lands at the same edge as the result register
	assign we    = issue && rd_wr && (q_instr.r.rd != '0);
	assign waddr = q_instr.r.rd;
	assign wdata = c_out;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits   <= CW'(OUT_CREDITS);
			res_valid <= 1'b0;
		end else begin
			res_valid <= issue;
			case ({issue, res_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			res_rd   <= q_instr.r.rd;
			res_data <= c_out;
			res_wr   <= rd_wr;
		end
	end

endmodule

//--- design/exec_top.sv
`timescale 1ns/1ns

module exec_top import rv32_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  instr_t   in_instr,
	input  data_t    in_pc,
	output logic     in_credit,
	output logic     res_valid,
	output reg_idx_t res_rd,
	output data_t    res_data,
	output logic     res_wr,
	input  logic     res_credit
);

	logic     q_valid, q_pop;
	instr_t   q_instr, alu_instr;
	data_t    q_pc;
	reg_idx_t rs1, rs2, waddr;
	data_t    rd1, rd2, wdata;
	data_t    a_in, b_in, c_out;
	logic     rd_wr, we;

	instr_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
		.clk, .rst_n, .in_valid, .in_instr, .in_pc, .in_credit,
		.q_valid, .q_instr, .q_pc, .q_pop
	);

	exec_stage #(.OUT_CREDITS(OUT_CREDITS)) u_stage (
		.clk, .rst_n, .q_valid, .q_instr, .q_pc, .q_pop,
		.rs1, .rs2, .rd1, .rd2,
		.alu_instr, .a_in, .b_in, .c_out, .rd_wr,
		.we, .waddr, .wdata,
		.res_valid, .res_rd, .res_data, .res_wr, .res_credit
	);

	reg_file u_regs (
		.clk, .rst_n, .rs1, .rs2, .rd1, .rd2, .we, .waddr, .wdata
	);

	alu u_alu (
		.instr(alu_instr), .a_in, .b_in, .c_out, .rd_wr
	);

endmodule

//--- testbench/tb_exec.sv
`timescale 1ns/1ns

module tb_exec import rv32_pkg::*; ();

	localparam int QUEUE_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int TIMEOUT = 50; // cycles per wait

	logic     clk = 1'b0;
	logic     rst_n;
	logic     in_valid;
	instr_t   in_instr;
	data_t    in_pc;
	logic     in_credit;
	logic     res_valid;
	reg_idx_t res_rd;
	data_t    res_data;
	logic     res_wr;
	logic     res_credit;

	int   beats_sent = 0;
	int   credits_returned = 0;
	int   owed = 0; // output credits not yet given back
	logic withhold = 1'b0;

	exec_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) DUT (
		.clk, .rst_n, .in_valid, .in_instr, .in_pc, .in_credit,
		.res_valid, .res_rd, .res_data, .res_wr, .res_credit
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (in_credit) begin
			credits_returned = credits_returned + 1;
		end
	end

	// each result earns one credit back a cycle later
	always @(posedge clk) begin
		if (res_valid) begin
			owed = owed + 1;
		end
		if (owed > 0 && !withhold) begin
			res_credit <= 1'b1;
			owed = owed - 1;
		end else begin
			res_credit <= 1'b0;
		end
	end

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(string name, data_t got, data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp));
		end
	endtask

	function automatic int held_credits();
		return QUEUE_DEPTH + credits_returned - beats_sent;
	endfunction

	function automatic data_t sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] r_type(logic [6:0] f7, reg_idx_t s2, reg_idx_t s1,
			funct3_t f3, reg_idx_t d);
		return {f7, s2, s1, f3, d, R};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, reg_idx_t s1, funct3_t f3,
			reg_idx_t d, opcode_t op);
		return {imm, s1, f3, d, op};
	endfunction

	function automatic logic [31:0] u_type(logic [19:0] imm, reg_idx_t d, opcode_t op);
		return {imm, d, op};
	endfunction

	function automatic logic [31:0] s_type(logic [11:0] imm, reg_idx_t s2, reg_idx_t s1);
		return {imm[11:5], s2, s1, 3'b010, imm[4:0], STORE}; // sw
	endfunction

	task automatic send(logic [31:0] word, data_t pc);
		int n;
		n = 0;
		@(negedge clk);
		while (held_credits() == 0) begin
			n++;
			if (n > TIMEOUT) begin
				abort_run("timeout: no input credit came back from the queue");
			end
			@(negedge clk);
		end
		@(posedge clk);
		in_valid <= 1'b1;
		in_instr <= word;
		in_pc    <= pc;
		beats_sent++;
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic expect_result(reg_idx_t rd, data_t data, logic wr);
		int n;
		n = 0;
		@(negedge clk);
		while (!res_valid) begin
			n++;
			if (n > TIMEOUT) begin
				abort_run("timeout: res_valid never went high");
			end
			@(negedge clk);
		end
		check("res_rd", data_t'(res_rd), data_t'(rd));
		check("res_data", res_data, data);
		check("res_wr", data_t'(res_wr), data_t'(wr));
	endtask

	task automatic arith_test();
		logic [11:0] ia, ib;
		data_t a, b;
		ia = 12'($urandom);
		ib = 12'($urandom);
		a = sext12(ia);
		b = sext12(ib);
		send(i_type(ia, 5'd0, ADD, 5'd1, I), 32'h0);
		expect_result(5'd1, a, 1'b1);
		send(i_type(ib, 5'd0, ADD, 5'd2, I), 32'h0);
		expect_result(5'd2, b, 1'b1);
		send(r_type(7'h00, 5'd2, 5'd1, ADD, 5'd3), 32'h0);
		expect_result(5'd3, a + b, 1'b1);
		send(r_type(7'h20, 5'd2, 5'd1, SUB, 5'd3), 32'h0);
		expect_result(5'd3, a - b, 1'b1);
		send(r_type(7'h00, 5'd2, 5'd1, AND, 5'd3), 32'h0);
		expect_result(5'd3, a & b, 1'b1);
		send(r_type(7'h00, 5'd2, 5'd1, OR, 5'd3), 32'h0);
		expect_result(5'd3, a | b, 1'b1);
		send(r_type(7'h00, 5'd2, 5'd1, XOR, 5'd3), 32'h0);
		expect_result(5'd3, a ^ b, 1'b1);
	endtask

	task automatic compare_shift_test();
		logic [4:0] sh;
		data_t v;
		sh = 5'($urandom_range(31, 1));
		v  = sext12(12'h810);
		send(i_type(12'hfff, 5'd0, ADD, 5'd1, I), 32'h0); // x1 = -1
		expect_result(5'd1, 32'hffff_ffff, 1'b1);
		send(i_type(12'h001, 5'd0, ADD, 5'd2, I), 32'h0);
		expect_result(5'd2, 32'd1, 1'b1);
		send(r_type(7'h00, 5'd2, 5'd1, SLT, 5'd3), 32'h0);
		expect_result(5'd3, 32'd1, 1'b1);
		send(r_type(7'h00, 5'd2, 5'd1, SLTU, 5'd3), 32'h0);
		expect_result(5'd3, 32'd0, 1'b1);
		send(r_type(7'h00, 5'd1, 5'd2, SLT, 5'd3), 32'h0);
		expect_result(5'd3, 32'd0, 1'b1);
		send(r_type(7'h00, 5'd1, 5'd2, SLTU, 5'd3), 32'h0);
		expect_result(5'd3, 32'd1, 1'b1);
		send(i_type(12'h810, 5'd0, ADD, 5'd4, I), 32'h0);
		expect_result(5'd4, v, 1'b1);
		send(i_type({7'h00, sh}, 5'd4, SLL, 5'd5, I), 32'h0);
		expect_result(5'd5, v << sh, 1'b1);
		send(i_type({7'h00, sh}, 5'd4, SRL, 5'd5, I), 32'h0);
		expect_result(5'd5, v >> sh, 1'b1);
		send(i_type({7'h20, sh}, 5'd4, SRA, 5'd5, I), 32'h0);
		expect_result(5'd5, (v >> sh) | ~(32'hffff_ffff >> sh), 1'b1); // sign fill
	endtask

	task automatic upper_addr_test();
		logic [19:0] ui;
		logic [11:0] off;
		data_t pc;
		ui  = 20'($urandom);
		off = 12'($urandom);
		pc  = $urandom & 32'hffff_fffc;
		send(u_type(ui, 5'd6, LUI), pc);
		expect_result(5'd6, {ui, 12'h000}, 1'b1);
		send(u_type(ui, 5'd7, AUIPC), pc);
		expect_result(5'd7, pc + {ui, 12'h000}, 1'b1);
		send(u_type(20'h0, 5'd1, JAL), pc);
		expect_result(5'd1, pc + 32'd4, 1'b1);
		send(i_type(12'h400, 5'd0, ADD, 5'd2, I), 32'h0);
		expect_result(5'd2, 32'h400, 1'b1);
		send(i_type(off, 5'd2, 3'b010, 5'd8, LOAD), 32'h0);
		expect_result(5'd8, 32'h400 + sext12(off), 1'b1);
		send(s_type(off, 5'd8, 5'd2), 32'h0);
		expect_result(off[4:0], 32'h400 + sext12(off), 1'b0); // rd field holds imm[4:0]
		send({7'h00, 5'd2, 5'd1, 3'b000, 5'd8, B}, pc);
		expect_result(5'd8, 32'h0, 1'b0);
	endtask

	task automatic zero_reg_test();
		send(i_type(12'd123, 5'd0, ADD, 5'd0, I), 32'h0);
		expect_result(5'd0, 32'd123, 1'b1);
		send(r_type(7'h00, 5'd0, 5'd0, ADD, 5'd5), 32'h0);
		expect_result(5'd5, 32'd0, 1'b1);
	endtask

	task automatic credit_flow_test();
		int n;
		n = 0;
		@(negedge clk);
		while (owed != 0 || res_credit) begin // let earlier credits settle
			n++;
			if (n > TIMEOUT) begin
				abort_run("timeout: output credits did not settle");
			end
			@(negedge clk);
		end
		withhold = 1'b1;
		send(i_type(12'd5, 5'd0, ADD, 5'd10, I), 32'h0);
		expect_result(5'd10, 32'd5, 1'b1);
		send(i_type(12'd7, 5'd10, ADD, 5'd11, I), 32'h0);
		expect_result(5'd11, 32'd12, 1'b1);
		send(r_type(7'h00, 5'd11, 5'd10, ADD, 5'd12), 32'h0);
		send(r_type(7'h20, 5'd10, 5'd12, SUB, 5'd13), 32'h0);
		send(i_type(12'hfff, 5'd13, ADD, 5'd14, I), 32'h0);
		send(r_type(7'h00, 5'd10, 5'd14, XOR, 5'd15), 32'h0);
		repeat (6) begin
			@(negedge clk);
			check("res_valid", data_t'(res_valid), 32'd0);
		end
		check("input credits held", data_t'(held_credits()), 32'd0);
		withhold = 1'b0;
		expect_result(5'd12, 32'd17, 1'b1);
		expect_result(5'd13, 32'd12, 1'b1);
		expect_result(5'd14, 32'd11, 1'b1);
		expect_result(5'd15, 32'd14, 1'b1); // 11 ^ 5
		n = 0;
		while (credits_returned < beats_sent) begin
			n++;
			if (n > TIMEOUT) begin
				abort_run("timeout: input credits did not all come back");
			end
			@(negedge clk);
		end
		check("in_credit pulses", data_t'(credits_returned), data_t'(beats_sent));
	endtask

	initial begin
		void'($urandom(32'he1ad_379f));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_instr   = '0;
		in_pc      = '0;
		res_credit = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		arith_test();
		compare_shift_test();
		upper_addr_test();
		zero_reg_test();
		credit_flow_test();
		$display("Everything OK");
		$finish;
	end

endmodule

//--- src.f
design/rv32_pkg.sv
design/reg_file.sv
design/instr_queue.sv
design/alu.sv
design/exec_stage.sv
design/exec_top.sv
testbench/tb_exec.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_exec with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal --top-module tb_exec -f src.f --Mdir obj_dir
	./obj_dir/Vtb_exec

clean:
	rm -rf obj_dir
